// ==== common/nora_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types and constants of the CPU bus glue
// Imported by the RTL blocks and the checker
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package nora_pkg;

    typedef logic [15:0] cpu_addr_t;        // CPU address, one word
    typedef logic [2:0]  phase_t;           // Index inside one CPU cycle
    typedef logic [3:0]  reg_off_t;         // Register offset in a slave window

    // Slave selected by the bus decoder
    typedef enum logic [1:0] {
        SEL_NONE = 2'd0,
        SEL_VIA  = 2'd1,
        SEL_PS2  = 2'd2
    } slv_sel_t;

    // clk6x cycles per CPU cycle
    parameter int PHASE_COUNT = 6;

    parameter phase_t PH_SETUP_CS   = 3'd1;  // Address is stable, open the access
    parameter phase_t PH_PHI2_RISE  = 3'd3;  // First phase with CPHI2 high
    parameter phase_t PH_RELEASE_WR = 3'd4;  // Write data is taken here
    parameter phase_t PH_RELEASE_CS = 3'd5;  // Last phase of the access

    // VIA register map
    parameter reg_off_t VIA_REG_ORB  = 4'd0;
    parameter reg_off_t VIA_REG_ORA  = 4'd1;
    parameter reg_off_t VIA_REG_DDRB = 4'd2;
    parameter reg_off_t VIA_REG_DDRA = 4'd3;

    // PS/2 register map
    parameter reg_off_t PS2_REG_CODE = 4'd0;
    parameter reg_off_t PS2_REG_STAT = 4'd1;

endpackage

// ==== common/nora_slv_if.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Internal slave bus, decoder to VIA and PS/2
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

interface nora_slv_if;
    import nora_pkg::*;

    reg_off_t    addr;              // Low nibble of the CPU address
    logic [7:0]  datawr;            // Write data, valid with datawr_valid
    logic        datawr_valid;      // One-cycle write pulse
    logic        rwn;               // 1 = read, 0 = write
    logic        req_via;           // Access window of the VIA
    logic        req_ps2;           // Access window of the keyboard port
    logic [7:0]  datard_via;        // Combinational from addr
    logic [7:0]  datard_ps2;

    modport decoder (output addr, datawr, datawr_valid, rwn, req_via, req_ps2,
                     input datard_via, datard_ps2);

    // One slave modport per slave, each with its own req and datard
    modport via_slave (input addr, datawr, datawr_valid, rwn, req_via,
                       output datard_via);
    modport ps2_slave (input addr, datawr, datawr_valid, rwn, req_ps2,
                       output datard_ps2);

endinterface

// ==== design/phaser.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Six-phase CPU cycle generator
// Makes CPHI2 and the bus strobes, parks on stop
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module phaser (
    input  logic clk6x,
    input  logic resetn,
    input  logic cpu_run_i,         // 0 = park the CPU at the next cycle end
    output logic cpu_phi2_o,        // CPU clock
    output logic stopped_o,         // CPU parked in phase 0
    output logic setup_cs_o,        // Phase 1 strobe
    output logic release_wr_o,      // Phase 4 strobe
    output logic release_cs_o       // Phase 5 strobe
);
    import nora_pkg::*;

    localparam phase_t LAST_PHASE = phase_t'(PHASE_COUNT - 1);

    phase_t phase_r;                // Current phase, 0..5
    logic   stopped_r;

    always_ff @(posedge clk6x)
    begin
        if (!resetn)
        begin
            phase_r   <= '0;
            stopped_r <= 1'b0;
        end
        else if (stopped_r)
        begin
            // Parked in phase 0 until run comes back
            if (cpu_run_i)
            begin
                phase_r   <= 3'd1;
                stopped_r <= 1'b0;
            end
        end
        else if (phase_r == LAST_PHASE)
        begin
            phase_r   <= '0;          // Cycle end, wrap around
            stopped_r <= !cpu_run_i;  // Run sampled only here
        end
        else
        begin
            phase_r <= phase_r + 3'd1;
        end
    end

    // Clock high in the second half of the cycle
    assign cpu_phi2_o = (phase_r >= PH_PHI2_RISE);
    assign stopped_o  = stopped_r;

    // Strobes decoded from the phase, one cycle each
    assign setup_cs_o   = (phase_r == PH_SETUP_CS);
    assign release_wr_o = (phase_r == PH_RELEASE_WR);
    assign release_cs_o = (phase_r == PH_RELEASE_CS);

endmodule

// ==== design/bus_decoder.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CPU bus decoder that routes accesses to slaves
// Driven by the phaser strobes with one access per cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module bus_decoder #(
    parameter nora_pkg::cpu_addr_t VIA_BASE = 16'h9F00,
    parameter nora_pkg::cpu_addr_t PS2_BASE = 16'h9F10
) (
    input  logic                clk6x,
    input  logic                resetn,
    input  nora_pkg::cpu_addr_t cpu_addr_i,
    input  logic                cpu_rwn_i,
    input  logic [7:0]          cpu_db_i,     // Write data from the CPU
    output logic [7:0]          cpu_db_o,     // Read data to the CPU
    output logic                cpu_db_oe_o,  // Drive enable for cpu_db_o
    input  logic                cpu_phi2_i,
    input  logic                setup_cs_i,
    input  logic                release_wr_i,
    input  logic                release_cs_i,
    nora_slv_if.decoder         slv
);
    import nora_pkg::*;

    reg_off_t   addr_r;             // Register offset of the running access
    logic       rwn_r;
    slv_sel_t   sel_r;              // SEL_NONE outside an access
    logic [7:0] datawr_r;
    logic       datawr_valid_r;

    // Upper 12 bits pick the 16-byte window
    function automatic slv_sel_t decode_sel(input cpu_addr_t a);
        if (a[15:4] == VIA_BASE[15:4])
            return SEL_VIA;
        else if (a[15:4] == PS2_BASE[15:4])
            return SEL_PS2;
        else
            return SEL_NONE;
    endfunction

    always_ff @(posedge clk6x)
    begin
        if (setup_cs_i)
            addr_r <= cpu_addr_i[3:0];  // Low nibble of the CPU address
        if (release_wr_i)
            datawr_r <= cpu_db_i;   // Bus data settled by phase 4
    end

    always_ff @(posedge clk6x)
    begin
        if (!resetn)
        begin
            rwn_r          <= 1'b1;
            sel_r          <= SEL_NONE;
            datawr_valid_r <= 1'b0;
        end
        else
        begin
            // Write pulse lands in phase 5
            datawr_valid_r <= release_wr_i && !rwn_r && (sel_r != SEL_NONE);
            if (setup_cs_i)
            begin
                rwn_r <= cpu_rwn_i;
                sel_r <= decode_sel(cpu_addr_i);
            end
            else if (release_cs_i)
            begin
                sel_r <= SEL_NONE;  // Reqs drop in the next phase 0
            end
        end
    end

    assign slv.addr         = addr_r;
    assign slv.datawr       = datawr_r;
    assign slv.datawr_valid = datawr_valid_r;
    assign slv.rwn          = rwn_r;
    assign slv.req_via      = (sel_r == SEL_VIA);
    assign slv.req_ps2      = (sel_r == SEL_PS2);

    // Read path back to the CPU
    assign cpu_db_o    = (sel_r == SEL_PS2) ? slv.datard_ps2 : slv.datard_via;
    assign cpu_db_oe_o = cpu_phi2_i && rwn_r && (sel_r != SEL_NONE);

endmodule

// ==== via/simple_via.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reduced 65C22, two GPIO ports with DDRs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module simple_via (
    input  logic        clk6x,
    input  logic        resetn,
    input  logic [7:0]  port_a_i,    // Pin levels of port A
    input  logic [7:0]  port_b_i,    // Pin levels of port B
    output logic [7:0]  port_a_o,    // ORA
    output logic [7:0]  port_b_o,    // ORB
    output logic [7:0]  ddr_a_o,     // 1 = output
    output logic [7:0]  ddr_b_o,
    nora_slv_if.via_slave slv
);
    import nora_pkg::*;

    logic [7:0] ora_r;
    logic [7:0] orb_r;
    logic [7:0] ddra_r;
    logic [7:0] ddrb_r;
    logic       wr_en;
    logic [7:0] pa_mix;              // Port A as the CPU sees it
    logic [7:0] pb_mix;

    assign wr_en = slv.req_via && slv.datawr_valid && !slv.rwn;

    // Register file, written in phase 5
    always_ff @(posedge clk6x)
    begin
        if (!resetn)
        begin
            ora_r  <= '0;
            orb_r  <= '0;
            ddra_r <= '0;           // All pins inputs
            ddrb_r <= '0;
        end
        else if (wr_en)
        begin
            case (slv.addr)
                VIA_REG_ORB:  orb_r  <= slv.datawr;
                VIA_REG_ORA:  ora_r  <= slv.datawr;
                VIA_REG_DDRB: ddrb_r <= slv.datawr;
                VIA_REG_DDRA: ddra_r <= slv.datawr;
                default: ;          // Timer offsets gone
            endcase
        end
    end

    // Output bits from ORx, input bits from the pins
    assign pa_mix = (ora_r & ddra_r) | (port_a_i & ~ddra_r);
    assign pb_mix = (orb_r & ddrb_r) | (port_b_i & ~ddrb_r);

    always_comb
    begin
        case (slv.addr)
            VIA_REG_ORB:  slv.datard_via = pb_mix;
            VIA_REG_ORA:  slv.datard_via = pa_mix;
            VIA_REG_DDRB: slv.datard_via = ddrb_r;
            VIA_REG_DDRA: slv.datard_via = ddra_r;
            default:      slv.datard_via = 8'h00;
        endcase
    end

    assign port_a_o = ora_r;
    assign port_b_o = orb_r;
    assign ddr_a_o  = ddra_r;
    assign ddr_b_o  = ddrb_r;

endmodule

// ==== ps2/ps2_port.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PS/2 keyboard receiver, device-to-host only
// Scan code and pending flag on the slave bus
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module ps2_port #(
    parameter int TICKS_PER_US   = 48,
    parameter int PS2_TIMEOUT_US = 100
) (
    input  logic clk6x,
    input  logic resetn,
    input  logic ps2_clk_i,          // Raw line, async
    input  logic ps2_data_i,
    nora_slv_if.ps2_slave slv
);
    import nora_pkg::*;

    localparam int TICK_W = $clog2(TICKS_PER_US);
    localparam int IDLE_W = $clog2(PS2_TIMEOUT_US + 1);

    logic [TICK_W-1:0] tick_cnt_r;
    logic              tick_r;               // 1 us pulse, one cycle
    logic [2:0]        clk_sync_r;           // Two sync flops plus edge history
    logic [1:0]        data_sync_r;
    logic              fall;
    logic [10:0]       shift_r;              // Start bit ends in [0]
    logic [3:0]        bit_cnt_r;
    logic [IDLE_W-1:0] idle_r;               // Microseconds since last edge
    logic              frame_done_r;
    logic [7:0]        code_r;
    logic              code_valid_r;         // Pending flag
    logic              req_q_r;
    logic              frame_ok;

    assign fall     = clk_sync_r[2] && !clk_sync_r[1];
    // Start 0, stop 1, odd parity over data and parity bit
    assign frame_ok = !shift_r[0] && shift_r[10] && (^shift_r[9:1]);

    always_ff @(posedge clk6x)
    begin
        clk_sync_r  <= {clk_sync_r[1:0], ps2_clk_i};
        data_sync_r <= {data_sync_r[0], ps2_data_i};
        if (fall)
            shift_r <= {data_sync_r[1], shift_r[10:1]};  // LSB first
        if (frame_done_r && frame_ok)
            code_r <= shift_r[8:1];                       // New frame overwrites
    end

    always_ff @(posedge clk6x)
    begin
        if (!resetn)
        begin
            tick_cnt_r   <= TICK_W'(TICKS_PER_US - 1);
            tick_r       <= 1'b0;
            bit_cnt_r    <= '0;
            idle_r       <= '0;
            frame_done_r <= 1'b0;
            code_valid_r <= 1'b0;
            req_q_r      <= 1'b0;
        end
        else
        begin
            tick_r       <= (tick_cnt_r == '0);
            tick_cnt_r   <= (tick_cnt_r == '0) ? TICK_W'(TICKS_PER_US - 1) : tick_cnt_r - 1'b1;
            frame_done_r <= fall && (bit_cnt_r == 4'd10);
            req_q_r      <= slv.req_ps2;
            if (fall)
            begin
                idle_r    <= '0;
                bit_cnt_r <= (bit_cnt_r == 4'd10) ? 4'd0 : bit_cnt_r + 4'd1;
            end
            else
            begin
                if (tick_r && (idle_r != IDLE_W'(PS2_TIMEOUT_US)))
                    idle_r <= idle_r + 1'b1;
                if (idle_r == IDLE_W'(PS2_TIMEOUT_US))
                    bit_cnt_r <= '0;   // Abandoned frame
            end
            // Code read ends when req falls, addr and rwn still held
            if (req_q_r && !slv.req_ps2 && slv.rwn && (slv.addr == PS2_REG_CODE))
                code_valid_r <= 1'b0;
            if (frame_done_r && frame_ok)
                code_valid_r <= 1'b1;  // Set wins over clear
        end
    end

    always_comb
    begin
        case (slv.addr)
            PS2_REG_CODE: slv.datard_ps2 = code_r;
            PS2_REG_STAT: slv.datard_ps2 = {7'b0, code_valid_r};
            default:      slv.datard_ps2 = 8'h00;
        endcase
    end

endmodule

// ==== design/board_io.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CPU LEDs from VIA port B, blinker default
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module board_io #(
    parameter int BLINK_BITS = 23    // LED0 toggles every 2^BLINK_BITS cycles
) (
    input  logic       clk6x,
    input  logic       resetn,
    input  logic [7:0] port_b_i,     // ORB
    input  logic [7:0] ddr_b_i,      // DDRB
    output logic [1:0] cpu_led_o,
    output logic [7:0] led_in_o      // Back to the VIA as port B pins
);

    logic [BLINK_BITS-1:0] blink_cnt_r;
    logic                  blink_r;

    // Free-running blinker
    always_ff @(posedge clk6x)
    begin
        if (!resetn)
        begin
            blink_cnt_r <= '0;
            blink_r     <= 1'b0;
        end
        else
        begin
            blink_cnt_r <= blink_cnt_r + 1'b1;
            if (&blink_cnt_r)
                blink_r <= !blink_r;  // Toggle on wrap
        end
    end

    // Output bit follows ORB, else the board default
    assign cpu_led_o[0] = ddr_b_i[0] ? port_b_i[0] : blink_r;
    assign cpu_led_o[1] = ddr_b_i[1] ? port_b_i[1] : 1'b1;

    assign led_in_o = {6'b0, cpu_led_o};

endmodule

// ==== design/nora_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Glue FPGA top, CPU bus side only
// Tristate pins split into data and enable ports
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module nora_top #(
    parameter nora_pkg::cpu_addr_t VIA_BASE = 16'h9F00,
    parameter nora_pkg::cpu_addr_t PS2_BASE = 16'h9F10,
    parameter int TICKS_PER_US   = 48,
    parameter int PS2_TIMEOUT_US = 100,
    parameter int BLINK_BITS     = 23
) (
    input  logic                clk6x,
    input  logic                resetn,
    input  logic                cpu_run_i,     // 0 = stop the CPU clock
    input  nora_pkg::cpu_addr_t cpu_addr_i,
    input  logic                cpu_rwn_i,
    input  logic [7:0]          cpu_db_i,
    output logic                cpu_phi2_o,    // CPHI2
    output logic                cpu_stopped_o,
    output logic [7:0]          cpu_db_o,
    output logic                cpu_db_oe_o,
    input  logic [7:0]          gpio_a_i,
    output logic [7:0]          gpio_a_o,      // ORA
    output logic [7:0]          gpio_a_oe_o,   // DDRA
    input  logic                ps2k_clk_i,
    input  logic                ps2k_data_i,
    output logic [1:0]          cpu_led_o
);

    logic       setup_cs;
    logic       release_wr;
    logic       release_cs;
    logic [7:0] via_orb;
    logic [7:0] via_ddrb;
    logic [7:0] led_in;              // LED levels as port B input

    nora_slv_if slv_bus ();

    phaser ph0 (
        .clk6x        (clk6x),
        .resetn       (resetn),
        .cpu_run_i    (cpu_run_i),
        .cpu_phi2_o   (cpu_phi2_o),
        .stopped_o    (cpu_stopped_o),
        .setup_cs_o   (setup_cs),
        .release_wr_o (release_wr),
        .release_cs_o (release_cs)
    );

    bus_decoder #(.VIA_BASE(VIA_BASE), .PS2_BASE(PS2_BASE)) busdec0 (
        .clk6x        (clk6x),
        .resetn       (resetn),
        .cpu_addr_i   (cpu_addr_i),
        .cpu_rwn_i    (cpu_rwn_i),
        .cpu_db_i     (cpu_db_i),
        .cpu_db_o     (cpu_db_o),
        .cpu_db_oe_o  (cpu_db_oe_o),
        .cpu_phi2_i   (cpu_phi2_o),
        .setup_cs_i   (setup_cs),
        .release_wr_i (release_wr),
        .release_cs_i (release_cs),
        .slv          (slv_bus.decoder)
    );

    simple_via via1 (
        .clk6x    (clk6x),
        .resetn   (resetn),
        .port_a_i (gpio_a_i),
        .port_b_i (led_in),
        .port_a_o (gpio_a_o),
        .port_b_o (via_orb),
        .ddr_a_o  (gpio_a_oe_o),
        .ddr_b_o  (via_ddrb),
        .slv      (slv_bus.via_slave)
    );

    ps2_port #(.TICKS_PER_US(TICKS_PER_US), .PS2_TIMEOUT_US(PS2_TIMEOUT_US)) ps2kbd (
        .clk6x      (clk6x),
        .resetn     (resetn),
        .ps2_clk_i  (ps2k_clk_i),
        .ps2_data_i (ps2k_data_i),
        .slv        (slv_bus.ps2_slave)
    );

    board_io #(.BLINK_BITS(BLINK_BITS)) bio0 (
        .clk6x     (clk6x),
        .resetn    (resetn),
        .port_b_i  (via_orb),
        .ddr_b_i   (via_ddrb),
        .cpu_led_o (cpu_led_o),
        .led_in_o  (led_in)
    );

endmodule

// ==== dv/tb_clkgen.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock and synchronous reset source
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_clkgen #(
    parameter real PERIOD_NS    = 4.0,
    parameter int  RESET_CYCLES = 4
) (
    output logic clk_o,
    output logic resetn_o
);
    initial
    begin
        clk_o    = 1'b0;
        resetn_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        resetn_o <= 1'b1;                    // Released on a rising edge
    end

    always #(PERIOD_NS / 2.0) clk_o = ~clk_o;

endmodule

// ==== dv/tb_checker.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reference model of the glue that watches the DUT ports
// Compares each CPU cycle and keeps the test counts
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_checker #(
    parameter logic [15:0] VIA_BASE = 16'h9F00,
    parameter logic [15:0] PS2_BASE = 16'h9F10,
    parameter int TICKS_PER_US   = 48,
    parameter int PS2_TIMEOUT_US = 100,
    parameter int BLINK_BITS     = 6
) (
    input  logic        clk6x,
    input  logic        resetn,
    input  logic [15:0] cpu_addr_i,
    input  logic        cpu_rwn_i,
    input  logic [7:0]  cpu_db_i,
    input  logic [7:0]  gpio_a_i,
    input  logic        ps2k_clk_i,
    input  logic        ps2k_data_i,
    input  logic        phi2_i,
    input  logic [7:0]  db_rd_i,         // DUT read data
    input  logic        db_oe_i,
    input  logic [7:0]  gpio_out_i,
    input  logic [7:0]  gpio_oe_i,
    input  logic [1:0]  led_i
);
    import nora_pkg::*;

    localparam int TIMEOUT_CYC = PS2_TIMEOUT_US * TICKS_PER_US;

    logic [7:0]  ora_m;
    logic [7:0]  orb_m;
    logic [7:0]  ddra_m;
    logic [7:0]  ddrb_m;
    logic [7:0]  code_m;                 // Last good scan code
    logic        pend_m;
    logic [10:0] ps2_bits;               // Frame bits by arrival index
    int          ps2_cnt;
    int          idle_cyc;
    logic        ps2_clk_q;
    logic        phi2_q;
    int          cyc;                    // Rising edges since reset release
    int          n_checks = 0;
    int          n_errs = 0;
    int          t_checks = 0;
    int          t_errs = 0;
    int          n_tests = 0;

    // Start 0, stop 1 and an odd number of ones in data and parity
    function automatic logic frame_ok(input logic [10:0] b);
        int ones;
        ones = 0;
        for (int i = 1; i <= 9; i++)
            ones += b[i];
        return !b[0] && b[10] && (ones % 2 == 1);
    endfunction

    // Each bit from the output register where its direction bit is 1, else from the pin
    function automatic logic [7:0] port_mix(input logic [7:0] out_r, input logic [7:0] ddr,
                                            input logic [7:0] pins);
        logic [7:0] m;
        for (int i = 0; i < 8; i++)
            m[i] = ddr[i] ? out_r[i] : pins[i];
        return m;
    endfunction

    function automatic logic [1:0] led_exp();
        logic blink;
        blink = cyc[BLINK_BITS];         // Toggles every 2^BLINK_BITS cycles
        return {ddrb_m[1] ? orb_m[1] : 1'b1, ddrb_m[0] ? orb_m[0] : blink};
    endfunction

    // Expected CPU read data at address a
    function automatic logic [7:0] read_exp(input logic [15:0] a);
        logic [7:0] pins_b;
        pins_b = {6'b0, led_exp()};
        if (a[15:4] == PS2_BASE[15:4])
            return (a[3:0] == PS2_REG_CODE) ? code_m :
                   (a[3:0] == PS2_REG_STAT) ? {7'b0, pend_m} : 8'h00;
        case (a[3:0])
            VIA_REG_ORB:  return port_mix(orb_m, ddrb_m, pins_b);
            VIA_REG_ORA:  return port_mix(ora_m, ddra_m, gpio_a_i);
            VIA_REG_DDRB: return ddrb_m;
            VIA_REG_DDRA: return ddra_m;
            default:      return 8'h00;
        endcase
    endfunction

    task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
        n_checks++;
        if (got !== exp)
        begin
            n_errs++;
            $display("FAILED %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic finish_test(input string name);
        n_tests++;
        $display("Test %0d %s: %0d checks, %0d errors", n_tests, name,
                 n_checks - t_checks, n_errs - t_errs);
        t_checks = n_checks;
        t_errs   = n_errs;
    endtask

    task automatic report();
        $display("Summary: %0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errs);
    endtask

    // One CPU access as seen in the first phi2-high phase
    task automatic bus_cycle();
        logic hit_via;
        logic hit_ps2;
        hit_via = (cpu_addr_i[15:4] == VIA_BASE[15:4]);
        hit_ps2 = (cpu_addr_i[15:4] == PS2_BASE[15:4]);
        check_eq($sformatf("bus enable at %h", cpu_addr_i), db_oe_i,
                 cpu_rwn_i && (hit_via || hit_ps2));
        if (cpu_rwn_i)
        begin
            if (hit_via || hit_ps2)
                check_eq($sformatf("read data at %h", cpu_addr_i), db_rd_i, read_exp(cpu_addr_i));
            if (hit_ps2 && cpu_addr_i[3:0] == PS2_REG_CODE)
                pend_m = 1'b0;           // Code read clears pending
        end
        else if (hit_via)
        begin
            case (cpu_addr_i[3:0])
                VIA_REG_ORB:  orb_m  = cpu_db_i;
                VIA_REG_ORA:  ora_m  = cpu_db_i;
                VIA_REG_DDRB: ddrb_m = cpu_db_i;
                VIA_REG_DDRA: ddra_m = cpu_db_i;
                default: ;
            endcase
        end
    endtask

    always @(posedge clk6x)
        cyc <= resetn ? cyc + 1 : 0;     // Same edge as the blinker

    always @(negedge clk6x)
    begin
        if (!resetn)
        begin
            {ora_m, orb_m, ddra_m, ddrb_m} = '0;
            pend_m    = 1'b0;
            ps2_cnt   = 0;
            idle_cyc  = 0;
            ps2_clk_q = 1'b1;
            phi2_q    = 1'b0;
        end
        else
        begin
            // Falling keyboard clock takes a bit
            if (ps2_clk_q && !ps2k_clk_i)
            begin
                ps2_bits[ps2_cnt] = ps2k_data_i;
                ps2_cnt++;
                idle_cyc = 0;
                if (ps2_cnt == 11)
                begin
                    ps2_cnt = 0;
                    if (frame_ok(ps2_bits))
                    begin
                        code_m = ps2_bits[8:1];
                        pend_m = 1'b1;
                    end
                end
            end
            else
            begin
                idle_cyc++;
                if (idle_cyc > TIMEOUT_CYC)
                    ps2_cnt = 0;         // Abandoned frame
            end
            ps2_clk_q = ps2k_clk_i;
            if (phi2_i && !phi2_q)
                bus_cycle();
            // DUT registers have settled by the cycle end
            if (!phi2_i && phi2_q)
            begin
                check_eq("gpio_a_o", gpio_out_i, ora_m);
                check_eq("gpio_a_oe_o", gpio_oe_i, ddra_m);
                check_eq("cpu_led_o", led_i, led_exp());
            end
            phi2_q = phi2_i;
        end
    end

endmodule

// ==== dv/tb_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench top that drives the CPU bus and keyboard line
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_top;

    localparam logic [15:0] VIA_BASE = 16'h9F00;
    localparam logic [15:0] PS2_BASE = 16'h9F10;
    localparam int US_CYC    = 48;                  // Cycles per DUT microsecond
    localparam int HALF_BIT  = 3 * US_CYC;          // 6 us PS/2 bit time
    localparam int FRAME_CYC = 22 * HALF_BIT;
    localparam int IDLE_CYC  = 110 * US_CYC;        // Past the 100 us timeout
    localparam int TEST_CYC  = 2000 + 7 * (FRAME_CYC + 600) + IDLE_CYC;
    localparam real WATCHDOG_NS = 2.0 * TEST_CYC * 4.0;

    logic        clk6x;
    logic        resetn;
    logic        cpu_run;
    logic [15:0] cpu_addr;
    logic        cpu_rwn;
    logic [7:0]  cpu_db_wr;
    logic [7:0]  gpio_a_in;
    logic        ps2k_clk;
    logic        ps2k_data;
    logic        phi2;
    logic        stopped;
    logic [7:0]  db_rd;
    logic        db_oe;
    logic [7:0]  gpio_a_out;
    logic [7:0]  gpio_a_oe;
    logic [1:0]  led;
    logic [15:0] lfsr_r;

    tb_clkgen clkgen0 (.clk_o(clk6x), .resetn_o(resetn));

    nora_top #(.VIA_BASE(VIA_BASE), .PS2_BASE(PS2_BASE), .BLINK_BITS(6)) dut0 (
        .clk6x(clk6x), .resetn(resetn), .cpu_run_i(cpu_run),
        .cpu_addr_i(cpu_addr), .cpu_rwn_i(cpu_rwn), .cpu_db_i(cpu_db_wr),
        .cpu_phi2_o(phi2), .cpu_stopped_o(stopped), .cpu_db_o(db_rd),
        .cpu_db_oe_o(db_oe), .gpio_a_i(gpio_a_in), .gpio_a_o(gpio_a_out),
        .gpio_a_oe_o(gpio_a_oe), .ps2k_clk_i(ps2k_clk), .ps2k_data_i(ps2k_data),
        .cpu_led_o(led)
    );

    tb_checker #(.VIA_BASE(VIA_BASE), .PS2_BASE(PS2_BASE), .BLINK_BITS(6)) chk0 (
        .clk6x(clk6x), .resetn(resetn), .cpu_addr_i(cpu_addr), .cpu_rwn_i(cpu_rwn),
        .cpu_db_i(cpu_db_wr), .gpio_a_i(gpio_a_in), .ps2k_clk_i(ps2k_clk),
        .ps2k_data_i(ps2k_data), .phi2_i(phi2), .db_rd_i(db_rd), .db_oe_i(db_oe),
        .gpio_out_i(gpio_a_out), .gpio_oe_i(gpio_a_oe), .led_i(led)
    );

    // Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic rand_byte(output logic [7:0] v);
        for (int i = 0; i < 8; i++)
        begin
            lfsr_r = lfsr_next(lfsr_r);      // One step per bit
            v[i]   = lfsr_r[0];
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk6x);
    endtask

    // One CPU cycle on the bus followed by an idle cycle
    task automatic cpu_access(input logic [15:0] a, input logic rwn, input logic [7:0] d);
        @(negedge phi2);
        @(posedge clk6x);                    // End of phase 0
        cpu_addr  <= a;
        cpu_rwn   <= rwn;
        cpu_db_wr <= d;
        @(negedge phi2);
        @(posedge clk6x);
        cpu_addr <= 16'h0000;                // Outside both windows
        cpu_rwn  <= 1'b1;
    endtask

    function automatic logic [10:0] make_frame(input logic [7:0] code, input logic bad_par);
        return {1'b1, ~(^code) ^ bad_par, code, 1'b0};
    endfunction

    task automatic send_frame(input logic [10:0] f, input int nbits);
        for (int i = 0; i < nbits; i++)
        begin
            @(posedge clk6x);
            ps2k_data <= f[i];               // LSB first
            wait_cycles(HALF_BIT);
            ps2k_clk <= 1'b0;
            wait_cycles(HALF_BIT);
            ps2k_clk <= 1'b1;
        end
        @(posedge clk6x);
        ps2k_data <= 1'b1;
    endtask

    // Status, code, status again
    task automatic read_ps2();
        cpu_access(PS2_BASE + 16'd1, 1'b1, 8'h00);
        cpu_access(PS2_BASE, 1'b1, 8'h00);
        cpu_access(PS2_BASE + 16'd1, 1'b1, 8'h00);
    endtask

    initial
    begin
        logic [7:0] v;
        logic [7:0] code;
        int         hi;
        int         lo;
        cpu_run   = 1'b1;
        cpu_addr  = 16'h0000;
        cpu_rwn   = 1'b1;
        cpu_db_wr = 8'h00;
        gpio_a_in = 8'h00;
        ps2k_clk  = 1'b1;                    // Idle line
        ps2k_data = 1'b1;
        lfsr_r    = 16'd58970;
        @(posedge resetn);
        @(negedge clk6x);
        chk0.check_eq("phi2 after reset", phi2, 1'b0);
        chk0.check_eq("db_oe after reset", db_oe, 1'b0);
        @(posedge phi2);
        @(negedge clk6x);
        hi = 0;
        while (phi2)
        begin
            hi++;
            @(negedge clk6x);
        end
        lo = 0;
        while (!phi2)
        begin
            lo++;
            @(negedge clk6x);
        end
        chk0.check_eq("phi2 high time", hi, 3);
        chk0.check_eq("phi2 period", hi + lo, 6);
        chk0.finish_test("reset and phases");

        @(posedge clk6x);
        cpu_run <= 1'b0;
        @(posedge stopped);
        @(negedge clk6x);
        hi = 0;
        repeat (12)
        begin
            hi += phi2;                      // Must stay low
            @(negedge clk6x);
        end
        chk0.check_eq("phi2 high while stopped", hi, 0);
        chk0.check_eq("stopped flag", stopped, 1'b1);
        @(posedge clk6x);
        cpu_run <= 1'b1;
        @(posedge phi2);
        @(negedge clk6x);
        chk0.check_eq("stopped after resume", stopped, 1'b0);
        chk0.finish_test("run/stop");

        repeat (4)
        begin
            for (int r = 0; r < 4; r++)
            begin
                rand_byte(v);
                cpu_access(VIA_BASE + 16'(r), 1'b0, v);
            end
            rand_byte(v);
            @(posedge clk6x);
            gpio_a_in <= v;
            for (int r = 0; r < 4; r++)
                cpu_access(VIA_BASE + 16'(r), 1'b1, 8'h00);
        end
        cpu_access(16'h9F20, 1'b1, 8'h00);  // No slave here
        cpu_access(16'h1234, 1'b1, 8'h00);
        chk0.finish_test("VIA registers");

        cpu_access(VIA_BASE + 16'd2, 1'b0, 8'h00);  // DDRB all inputs
        @(negedge clk6x);
        v[0] = led[0];
        while (led[0] === v[0])
            @(negedge clk6x);
        v[0] = led[0];
        hi = 0;
        while (led[0] === v[0])
        begin
            @(negedge clk6x);
            hi++;
        end
        chk0.check_eq("LED0 blink half period", hi, 64);
        chk0.check_eq("LED1 default", led[1], 1'b1);
        cpu_access(VIA_BASE + 16'd2, 1'b0, 8'h03);
        rand_byte(v);
        cpu_access(VIA_BASE, 1'b0, v);
        cpu_access(VIA_BASE, 1'b1, 8'h00);  // Reads back LED levels
        @(negedge clk6x);
        chk0.check_eq("LEDs follow ORB", led, v[1:0]);
        chk0.finish_test("LEDs");

        repeat (4)
        begin
            rand_byte(code);
            send_frame(make_frame(code, 1'b0), 11);
            wait_cycles(10 * US_CYC);
            read_ps2();
            chk0.check_eq("model scan code", chk0.code_m, code);
        end
        rand_byte(code);
        send_frame(make_frame(code, 1'b1), 11);
        wait_cycles(10 * US_CYC);
        cpu_access(PS2_BASE + 16'd1, 1'b1, 8'h00);
        chk0.check_eq("pending after bad parity", chk0.pend_m, 1'b0);
        chk0.finish_test("PS/2 receive");

        rand_byte(code);
        send_frame(make_frame(code, 1'b0), 5);     // Dropped halfway
        wait_cycles(IDLE_CYC);
        rand_byte(code);
        send_frame(make_frame(code, 1'b0), 11);
        wait_cycles(10 * US_CYC);
        read_ps2();
        chk0.check_eq("code after timeout", chk0.code_m, code);
        chk0.finish_test("PS/2 timeout");

        chk0.report();
        if (chk0.n_errs == 0)
        begin
            $display("PASS: all tests");
        end
        else
        begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // Watchdog at twice the expected run length
    initial
    begin
        #(WATCHDOG_NS);
        $display("Watchdog expired, the tests did not finish in time");
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

// ==== build.f ====
common/nora_pkg.sv
common/nora_slv_if.sv
design/phaser.sv
design/bus_decoder.sv
via/simple_via.sv
ps2/ps2_port.sv
design/board_io.sv
design/nora_top.sv
dv/tb_clkgen.sv
dv/tb_checker.sv
dv/tb_top.sv
